// File: src.f
+incdir+design
+incdir+bench
design/decode_pkg.sv
design/imm_gen.sv
design/instr_decoder.sv
design/elastic_buf.sv
design/decode_stage.sv
bench/tb_decode.sv

// File: run.sh
#!/bin/sh
# Build the decode stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps --top-module tb_decode -f src.f

./obj_dir/Vtb_decode | tee sim.log

if grep -q "Test FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation passed"

// File: bench/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Expected output item plus the stall bit the scheduler should see
typedef struct packed {
    decode_pkg::decoded_t dec;
    logic                 wstall;
} expect_t;

function automatic expect_t ref_decode(
    input logic [`DEC_INSTR_W-1:0] ins,
    input logic [`DEC_INSTR_W-1:0] pc,
    input logic [`DEC_WID_W-1:0]   wid
);
    expect_t     e;
    logic [2:0]  f3;
    logic        rd_used;
    logic [3:0]  alu_code;
    logic [3:0]  br_code;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;

    f3      = ins[14:12];
    rd_used = 1'b0;
    imm_i   = $signed(ins) >>> 20;
    imm_s   = (imm_i & ~32'h1F) | {27'b0, ins[11:7]};
    imm_b   = $signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0, 19'b0}) >>> 19;
    imm_j   = $signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0, 11'b0}) >>> 11;

    case (f3)
        3'd0: alu_code = (ins[6:0] == 7'h33 && ins[30]) ? 4'd1 : 4'd0;
        3'd5: alu_code = ins[30] ? 4'd7 : 4'd6; // SRA or SRL
        3'd6: alu_code = 4'd8;
        3'd7: alu_code = 4'd9;
        default: alu_code = {1'b0, f3} + 4'd1;
    endcase

    case (f3)
        3'd1: br_code = 4'd1;
        3'd4, 3'd5, 3'd6, 3'd7: br_code = {1'b0, f3} - 4'd2;
        default: br_code = 4'd0; // EQ, also the reserved codes
    endcase

    e         = '0;
    e.dec.wid = wid;
    e.dec.pc  = pc;
    case (ins[6:0])
        7'h13: begin
            e.dec.op      = alu_code;
            e.dec.use_imm = 1'b1;
            e.dec.rs1     = ins[19:15];
            e.dec.imm     = (f3[1:0] == 2'b01) ? {27'b0, ins[24:20]} : imm_i;
            rd_used       = 1'b1;
        end
        7'h33: begin
            e.dec.op  = alu_code;
            e.dec.rs1 = ins[19:15];
            e.dec.rs2 = ins[24:20];
            rd_used   = 1'b1;
        end
        7'h37, 7'h17: begin
            e.dec.op      = (ins[5]) ? decode_pkg::ALU_LUI : decode_pkg::ALU_AUIPC;
            e.dec.use_pc  = ~ins[5];
            e.dec.use_imm = 1'b1;
            e.dec.imm     = ins & 32'hFFFF_F000;
            rd_used       = 1'b1;
        end
        7'h6F: begin
            e.dec.op      = decode_pkg::BR_JAL;
            e.dec.mod     = 3'b001;
            e.dec.use_pc  = 1'b1;
            e.dec.use_imm = 1'b1;
            e.dec.imm     = imm_j;
            e.wstall      = 1'b1;
            rd_used       = 1'b1;
        end
        7'h67: begin
            e.dec.op      = decode_pkg::BR_JALR;
            e.dec.mod     = 3'b001;
            e.dec.use_imm = 1'b1;
            e.dec.rs1     = ins[19:15];
            e.dec.imm     = imm_i;
            e.wstall      = 1'b1;
            rd_used       = 1'b1;
        end
        7'h63: begin
            e.dec.op      = br_code;
            e.dec.mod     = 3'b001;
            e.dec.use_pc  = 1'b1;
            e.dec.use_imm = 1'b1;
            e.dec.rs1     = ins[19:15];
            e.dec.rs2     = ins[24:20];
            e.dec.imm     = imm_b;
            e.wstall      = 1'b1;
        end
        7'h03: begin
            e.dec.unit    = decode_pkg::EX_LSU;
            e.dec.op      = {1'b0, f3};
            e.dec.use_imm = 1'b1;
            e.dec.rs1     = ins[19:15];
            e.dec.imm     = imm_i;
            rd_used       = 1'b1;
        end
        7'h23: begin
            e.dec.unit    = decode_pkg::EX_LSU;
            e.dec.op      = {1'b1, f3}; // Store flag on top
            e.dec.use_imm = 1'b1;
            e.dec.rs1     = ins[19:15];
            e.dec.rs2     = ins[24:20];
            e.dec.imm     = imm_s;
        end
        7'h0F: begin
            e.dec.unit = decode_pkg::EX_LSU;
            e.dec.op   = decode_pkg::LSU_FENCE;
        end
        7'h73: begin
            e.wstall = 1'b1;
            rd_used  = 1'b1;
            if (f3[1:0] != 2'b00) begin
                e.dec.unit    = decode_pkg::EX_SFU;
                e.dec.op      = {2'b00, f3[1:0]};
                e.dec.use_imm = f3[2];
                e.dec.imm     = {20'b0, ins[31:20]};
                if (f3[2]) begin
                    e.dec.imm[16:12] = ins[19:15]; // zimm next to the CSR address
                end else begin
                    e.dec.rs1 = ins[19:15];
                end
            end else begin
                case (ins[31:20])
                    12'h001: e.dec.op = decode_pkg::BR_EBREAK;
                    12'h002: e.dec.op = decode_pkg::BR_URET;
                    12'h102: e.dec.op = decode_pkg::BR_SRET;
                    12'h302: e.dec.op = decode_pkg::BR_MRET;
                    default: e.dec.op = decode_pkg::BR_ECALL;
                endcase
                e.dec.mod     = 3'b001;
                e.dec.use_pc  = 1'b1;
                e.dec.use_imm = 1'b1;
                e.dec.imm     = 32'd4;
            end
        end
        default: ;
    endcase

    if (rd_used) begin
        e.dec.rd = ins[11:7];
    end
    e.dec.wb = rd_used && (ins[11:7] != 5'd0);
    return e;
endfunction

`endif

// File: bench/tb_decode.sv
`timescale 1ns/100ps
`include "decode_cfg.svh"

module tb_decode;

    localparam int WAIT_LIMIT   = 200;
    localparam int NUM_RANDOM   = 500;
    localparam int NUM_DIRECTED = 24;

    localparam logic [31:0] DIRECTED [NUM_DIRECTED] = '{
        32'hFFB10093, 32'h40725193, 32'h407302B3, 32'h00C5F6B3, // addi srai sub and
        32'hABCDE437, 32'h12345497, 32'hFF9FF0EF, 32'h00008067, // lui auipc jal jalr
        32'hFE2088E3, 32'h0041E663, 32'h00812503, 32'hFFF1C583, // beq bltu lw lbu
        32'hFE512E23, 32'h006081A3, 32'h0FF0000F, 32'h300110F3, // sw sb fence csrrw
        32'h3412E1F3, 32'h30533273, 32'h00000073, 32'h00100073, // csrrsi csrrc ecall ebreak
        32'h30200073, 32'h10200073, 32'h00100013, 32'h00100293  // mret sret, x0 vs x5
    };

    localparam logic [6:0] KEPT_OPC [11] = '{
        7'h13, 7'h33, 7'h37, 7'h17, 7'h6F, 7'h67, 7'h63, 7'h03, 7'h23, 7'h0F, 7'h73
    };

    localparam logic [11:0] SYS_F12 [4] = '{12'h001, 12'h002, 12'h102, 12'h302};

    logic                    clk;
    logic                    i_rst_n;
    logic                    i_valid;
    logic                    o_ready;
    logic [`DEC_INSTR_W-1:0] i_instr;
    logic [`DEC_INSTR_W-1:0] i_pc;
    logic [`DEC_WID_W-1:0]   i_wid;
    logic                    o_valid;
    logic                    i_ready;
    logic [`DEC_WID_W-1:0]   o_wid;
    logic [`DEC_INSTR_W-1:0] o_pc;
    decode_pkg::ex_unit_e    o_unit;
    logic [3:0]              o_op;
    decode_pkg::op_mod_t     o_mod;
    logic                    o_use_pc;
    logic                    o_use_imm;
    logic [`DEC_INSTR_W-1:0] o_imm;
    logic                    o_wb;
    logic [`DEC_REG_W-1:0]   o_rd;
    logic [`DEC_REG_W-1:0]   o_rs1;
    logic [`DEC_REG_W-1:0]   o_rs2;
    logic                    o_sched_valid;
    logic [`DEC_WID_W-1:0]   o_sched_wid;
    logic                    o_sched_wstall;

    int         errors;
    logic [1:0] ready_mode; // 0 hold low, 1 high, 2 random
    logic       aborted;
    logic       xfer_pending; // Input transfer due on the next rising edge

    `include "decode_model.svh"

    expect_t exp_q [$];
    expect_t sent_item;

    decode_stage DUT (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_valid        (i_valid),
        .o_ready        (o_ready),
        .i_instr        (i_instr),
        .i_pc           (i_pc),
        .i_wid          (i_wid),
        .o_valid        (o_valid),
        .i_ready        (i_ready),
        .o_wid          (o_wid),
        .o_pc           (o_pc),
        .o_unit         (o_unit),
        .o_op           (o_op),
        .o_mod          (o_mod),
        .o_use_pc       (o_use_pc),
        .o_use_imm      (o_use_imm),
        .o_imm          (o_imm),
        .o_wb           (o_wb),
        .o_rd           (o_rd),
        .o_rs1          (o_rs1),
        .o_rs2          (o_rs2),
        .o_sched_valid  (o_sched_valid),
        .o_sched_wid    (o_sched_wid),
        .o_sched_wstall (o_sched_wstall)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Checks done, errors: %0d, items left: %0d", errors, exp_q.size());
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send(input logic [31:0] instr, input logic [31:0] pc, input logic [1:0] wid);
        int waits;
        if (aborted) begin
            return;
        end
        waits   = 0;
        i_valid = 1'b1;
        i_instr = instr;
        i_pc    = pc;
        i_wid   = wid;
        while (!o_ready && waits < WAIT_LIMIT) begin
            @(negedge clk);
            waits++;
        end
        if (!o_ready) begin
            errors++;
            aborted = 1'b1;
            i_valid = 1'b0;
            $display("Timeout: stage never accepted instruction %h", instr);
        end else begin
            sent_item = ref_decode(instr, pc, wid);
            exp_q.push_back(sent_item);
            xfer_pending = 1'b1;
            @(negedge clk);
            xfer_pending = 1'b0;
            i_valid      = 1'b0;
        end
    endtask

    task automatic drain();
        int waits;
        if (aborted) begin
            return;
        end
        waits = 0;
        while (exp_q.size() != 0 && waits < WAIT_LIMIT) begin
            @(negedge clk);
            waits++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            aborted = 1'b1;
            $display("Timeout: %0d items never came out of the stage", exp_q.size());
        end
    endtask

    function automatic logic [31:0] random_instr();
        logic [31:0] w;
        int          sel;
        w      = $urandom;
        sel    = $urandom_range(10);
        w[6:0] = KEPT_OPC[sel];
        if (w[6:0] == 7'h73 && $urandom_range(1) == 0) begin
            sel       = $urandom_range(3);
            w[31:20]  = SYS_F12[sel]; // Hit the trap returns too
            w[14:12]  = 3'b000;
        end
        return w;
    endfunction

    initial begin
        i_ready = 1'b1;
        forever begin
            @(negedge clk);
            case (ready_mode)
                2'd0: i_ready = 1'b0;
                2'd1: i_ready = 1'b1;
                default: i_ready = ($urandom_range(3) != 0);
            endcase
        end
    end

    // Output side scoreboard
    always @(posedge clk) begin
        expect_t e;
        if (i_rst_n && o_valid && i_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Output transfer at %0t with no instruction outstanding", $time);
            end else begin
                e = exp_q.pop_front();
                check_val("wid", 32'(o_wid), 32'(e.dec.wid));
                check_val("pc", o_pc, e.dec.pc);
                check_val("unit", 32'(o_unit), 32'(e.dec.unit));
                check_val("op", 32'(o_op), 32'(e.dec.op));
                check_val("mod", 32'(o_mod), 32'(e.dec.mod));
                check_val("use_pc", 32'(o_use_pc), 32'(e.dec.use_pc));
                check_val("use_imm", 32'(o_use_imm), 32'(e.dec.use_imm));
                check_val("imm", o_imm, e.dec.imm);
                check_val("wb", 32'(o_wb), 32'(e.dec.wb));
                check_val("rd", 32'(o_rd), 32'(e.dec.rd));
                check_val("rs1", 32'(o_rs1), 32'(e.dec.rs1));
                check_val("rs2", 32'(o_rs2), 32'(e.dec.rs2));
            end
        end
    end

    // Scheduler notice follows the input transfer exactly
    always @(posedge clk) begin
        if (i_rst_n) begin
            check_val("sched_valid", 32'(o_sched_valid), 32'(xfer_pending));
            if (xfer_pending) begin
                check_val("sched_wid", 32'(o_sched_wid), 32'(sent_item.dec.wid));
                check_val("sched_wstall", 32'(o_sched_wstall), 32'(sent_item.wstall));
            end
        end
    end

    initial begin
        int k;
        int n;
        void'($urandom(99));
        errors       = 0;
        aborted      = 1'b0;
        xfer_pending = 1'b0;
        ready_mode   = 2'd1;
        i_rst_n      = 1'b0;
        i_valid      = 1'b0;
        i_instr      = '0;
        i_pc         = '0;
        i_wid        = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
        @(negedge clk);
        check_val("o_valid after reset", 32'(o_valid), 32'd0);
        check_val("o_ready after reset", 32'(o_ready), 32'd1);
        check_val("o_sched_valid after reset", 32'(o_sched_valid), 32'd0);

        for (k = 0; k < NUM_DIRECTED; k++) begin
            send(DIRECTED[k], 32'h0000_1000 + 32'(k * 4), 2'(k));
        end
        drain();

        // Downstream stalled, buffer must fill at two
        ready_mode = 2'd0;
        repeat (2) @(negedge clk);
        send(DIRECTED[2], 32'h0000_2000, 2'd1);
        send(DIRECTED[8], 32'h0000_2004, 2'd2);
        repeat (3) begin
            check_val("o_ready with two held", 32'(o_ready), 32'd0);
            @(negedge clk);
        end
        ready_mode = 2'd1;
        send(DIRECTED[12], 32'h0000_2008, 2'd3);
        drain();

        ready_mode = 2'd2;
        for (n = 0; n < NUM_RANDOM; n++) begin
            if ($urandom_range(3) == 0) begin
                i_valid = 1'b0;
                @(negedge clk);
            end
            send(random_instr(), $urandom & 32'hFFFF_FFFC, 2'($urandom_range(3)));
        end
        ready_mode = 2'd1;
        drain();
        finish_run();
    end

endmodule

// File: design/decode_stage.sv
`timescale 1ns/100ps
`include "decode_cfg.svh"

module decode_stage (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_valid,
    output logic                    o_ready,
    input  logic [`DEC_INSTR_W-1:0] i_instr,
    input  logic [`DEC_INSTR_W-1:0] i_pc,
    input  logic [`DEC_WID_W-1:0]   i_wid,
    output logic                    o_valid,
    input  logic                    i_ready,
    output logic [`DEC_WID_W-1:0]   o_wid,
    output logic [`DEC_INSTR_W-1:0] o_pc,
    output decode_pkg::ex_unit_e    o_unit,
    output logic [3:0]              o_op,
    output decode_pkg::op_mod_t     o_mod,
    output logic                    o_use_pc,
    output logic                    o_use_imm,
    output logic [`DEC_INSTR_W-1:0] o_imm,
    output logic                    o_wb,
    output logic [`DEC_REG_W-1:0]   o_rd,
    output logic [`DEC_REG_W-1:0]   o_rs1,
    output logic [`DEC_REG_W-1:0]   o_rs2,
    output logic                    o_sched_valid,
    output logic [`DEC_WID_W-1:0]   o_sched_wid,
    output logic                    o_sched_wstall
);

    decode_pkg::decoded_t in_data;
    decode_pkg::decoded_t out_data;
    logic                 dec_wstall;

    instr_decoder u_decoder (
        .i_instr   (i_instr),
        .o_unit    (in_data.unit),
        .o_op      (in_data.op),
        .o_mod     (in_data.mod),
        .o_use_pc  (in_data.use_pc),
        .o_use_imm (in_data.use_imm),
        .o_wb      (in_data.wb),
        .o_rd      (in_data.rd),
        .o_rs1     (in_data.rs1),
        .o_rs2     (in_data.rs2),
        .o_wstall  (dec_wstall)
    );

    imm_gen u_imm_gen (
        .i_instr (i_instr),
        .o_imm   (in_data.imm)
    );

    assign in_data.wid = i_wid;
    assign in_data.pc  = i_pc;

    elastic_buf #(
        .payload_t (decode_pkg::decoded_t),
        .DEPTH     (`DEC_BUF_DEPTH)
    ) u_out_buf (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .o_ready (o_ready),
        .i_data  (in_data),
        .o_valid (o_valid),
        .i_ready (i_ready),
        .o_data  (out_data)
    );

    assign o_wid     = out_data.wid;
    assign o_pc      = out_data.pc;
    assign o_unit    = out_data.unit;
    assign o_op      = out_data.op;
    assign o_mod     = out_data.mod;
    assign o_use_pc  = out_data.use_pc;
    assign o_use_imm = out_data.use_imm;
    assign o_imm     = out_data.imm;
    assign o_wb      = out_data.wb;
    assign o_rd      = out_data.rd;
    assign o_rs1     = out_data.rs1;
    assign o_rs2     = out_data.rs2;

    // Scheduler sees every accepted instruction in its accept cycle
    assign o_sched_valid  = i_valid && o_ready;
    assign o_sched_wid    = i_wid;
    assign o_sched_wstall = dec_wstall;

endmodule

// File: design/elastic_buf.sv
`timescale 1ns/100ps

module elastic_buf #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     i_rst_n,
    input  logic     i_valid,
    output logic     o_ready,
    input  payload_t i_data,
    output logic     o_valid,
    input  logic     i_ready,
    output payload_t o_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic             full_r;
    logic             push;
    logic             pop;

    assign push = i_valid && !full_r;
    assign pop  = o_valid && i_ready;
    assign count_next = count + CNT_W'(push) - CNT_W'(pop);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full_r <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count  <= count_next;
            full_r <= (count_next == CNT_W'(DEPTH)); // Ready stays a flop output
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    assign o_ready = !full_r;
    assign o_valid = (count != '0);
    assign o_data  = mem[rd_ptr];

endmodule

// File: design/instr_decoder.sv
`timescale 1ns/100ps
`include "decode_cfg.svh"

module instr_decoder (
    input  logic [`DEC_INSTR_W-1:0] i_instr,
    output decode_pkg::ex_unit_e    o_unit,
    output logic [3:0]              o_op,
    output decode_pkg::op_mod_t     o_mod,
    output logic                    o_use_pc,
    output logic                    o_use_imm,
    output logic                    o_wb,
    output logic [`DEC_REG_W-1:0]   o_rd,
    output logic [`DEC_REG_W-1:0]   o_rs1,
    output logic [`DEC_REG_W-1:0]   o_rs2,
    output logic                    o_wstall
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] upper12;
    logic [`DEC_REG_W-1:0] rd;
    logic [`DEC_REG_W-1:0] rs1;
    logic [`DEC_REG_W-1:0] rs2;
    logic use_rd;

    decode_pkg::alu_op_e alu_sel;
    decode_pkg::br_op_e  br_sel;
    decode_pkg::br_op_e  sys_sel;
    decode_pkg::sfu_op_e csr_sel;

    assign opcode  = i_instr[6:0];
    assign funct3  = i_instr[14:12];
    assign funct7  = i_instr[31:25];
    assign upper12 = i_instr[31:20];
    assign rd      = i_instr[11:7];
    assign rs1     = i_instr[19:15];
    assign rs2     = i_instr[24:20];

    always_comb begin
        case (funct3)
            3'h0: begin
                // SUB exists only in the register form
                if (opcode == decode_pkg::OPC_OP && funct7[5]) begin
                    alu_sel = decode_pkg::ALU_SUB;
                end else begin
                    alu_sel = decode_pkg::ALU_ADD;
                end
            end
            3'h1: alu_sel = decode_pkg::ALU_SLL;
            3'h2: alu_sel = decode_pkg::ALU_SLT;
            3'h3: alu_sel = decode_pkg::ALU_SLTU;
            3'h4: alu_sel = decode_pkg::ALU_XOR;
            3'h5: alu_sel = funct7[5] ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
            3'h6: alu_sel = decode_pkg::ALU_OR;
            default: alu_sel = decode_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'h1: br_sel = decode_pkg::BR_NE;
            3'h4: br_sel = decode_pkg::BR_LT;
            3'h5: br_sel = decode_pkg::BR_GE;
            3'h6: br_sel = decode_pkg::BR_LTU;
            3'h7: br_sel = decode_pkg::BR_GEU;
            default: br_sel = decode_pkg::BR_EQ; // Reserved codes fall back to EQ
        endcase
    end

    always_comb begin
        case (upper12)
            12'h001: sys_sel = decode_pkg::BR_EBREAK;
            12'h002: sys_sel = decode_pkg::BR_URET;
            12'h102: sys_sel = decode_pkg::BR_SRET;
            12'h302: sys_sel = decode_pkg::BR_MRET;
            default: sys_sel = decode_pkg::BR_ECALL;
        endcase
    end

    always_comb begin
        case (funct3[1:0])
            2'h1: csr_sel = decode_pkg::SFU_CSRRW;
            2'h2: csr_sel = decode_pkg::SFU_CSRRS;
            default: csr_sel = decode_pkg::SFU_CSRRC;
        endcase
    end

    always_comb begin
        o_unit    = decode_pkg::EX_ALU;
        o_op      = '0;
        o_mod     = '0;
        o_use_pc  = 1'b0;
        o_use_imm = 1'b0;
        o_wstall  = 1'b0;
        o_rd      = '0;
        o_rs1     = '0;
        o_rs2     = '0;
        use_rd    = 1'b0;
        case (opcode)
            decode_pkg::OPC_OP_IMM: begin
                o_op      = alu_sel;
                o_use_imm = 1'b1;
                use_rd    = 1'b1;
                o_rd      = rd;
                o_rs1     = rs1;
            end
            decode_pkg::OPC_OP: begin
                o_op   = alu_sel;
                use_rd = 1'b1;
                o_rd   = rd;
                o_rs1  = rs1;
                o_rs2  = rs2;
            end
            decode_pkg::OPC_LUI,
            decode_pkg::OPC_AUIPC: begin
                o_op      = opcode[5] ? decode_pkg::ALU_LUI : decode_pkg::ALU_AUIPC;
                o_use_pc  = ~opcode[5];
                o_use_imm = 1'b1;
                use_rd    = 1'b1;
                o_rd      = rd;
            end
            decode_pkg::OPC_JAL: begin
                o_op      = decode_pkg::BR_JAL;
                o_mod[0]  = 1'b1;
                o_use_pc  = 1'b1;
                o_use_imm = 1'b1;
                o_wstall  = 1'b1;
                use_rd    = 1'b1;
                o_rd      = rd;
            end
            decode_pkg::OPC_JALR: begin
                o_op      = decode_pkg::BR_JALR;
                o_mod[0]  = 1'b1;
                o_use_imm = 1'b1;
                o_wstall  = 1'b1;
                use_rd    = 1'b1;
                o_rd      = rd;
                o_rs1     = rs1;
            end
            decode_pkg::OPC_BRANCH: begin
                o_op      = br_sel;
                o_mod[0]  = 1'b1;
                o_use_pc  = 1'b1;
                o_use_imm = 1'b1;
                o_wstall  = 1'b1;
                o_rs1     = rs1;
                o_rs2     = rs2;
            end
            decode_pkg::OPC_LOAD: begin
                o_unit    = decode_pkg::EX_LSU;
                o_op      = {1'b0, funct3};
                o_use_imm = 1'b1;
                use_rd    = 1'b1;
                o_rd      = rd;
                o_rs1     = rs1;
            end
            decode_pkg::OPC_STORE: begin
                o_unit    = decode_pkg::EX_LSU;
                o_op      = {1'b1, funct3};
                o_use_imm = 1'b1;
                o_rs1     = rs1;
                o_rs2     = rs2;
            end
            decode_pkg::OPC_FENCE: begin
                o_unit = decode_pkg::EX_LSU;
                o_op   = decode_pkg::LSU_FENCE;
            end
            decode_pkg::OPC_SYSTEM: begin
                o_wstall = 1'b1;
                use_rd   = 1'b1;
                o_rd     = rd;
                if (funct3[1:0] != 2'b00) begin
                    o_unit    = decode_pkg::EX_SFU;
                    o_op      = csr_sel;
                    o_use_imm = funct3[2]; // CSRxxI takes zimm, not rs1
                    o_rs1     = funct3[2] ? '0 : rs1;
                end else begin
                    o_op      = sys_sel;
                    o_mod[0]  = 1'b1;
                    o_use_pc  = 1'b1;
                    o_use_imm = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // No writeback to x0
    assign o_wb = use_rd && (o_rd != '0);

endmodule

// File: design/imm_gen.sv
`timescale 1ns/100ps
`include "decode_cfg.svh"

module imm_gen (
    input  logic [`DEC_INSTR_W-1:0] i_instr,
    output logic [`DEC_INSTR_W-1:0] o_imm
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [11:0] i_imm;
    logic [11:0] s_imm;
    logic [12:0] b_imm;
    logic [20:0] j_imm;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign i_imm  = i_instr[31:20];
    assign s_imm  = {i_instr[31:25], i_instr[11:7]};
    assign b_imm  = {i_instr[31], i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign j_imm  = {i_instr[31], i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

    always_comb begin
        o_imm = '0; // FENCE, OP and unknown opcodes
        case (opcode)
            decode_pkg::OPC_OP_IMM: begin
                if (funct3[1:0] == 2'b01) begin
                    o_imm = {27'b0, i_instr[24:20]}; // Shift amount only
                end else begin
                    o_imm = {{20{i_imm[11]}}, i_imm};
                end
            end
            decode_pkg::OPC_JALR,
            decode_pkg::OPC_LOAD:   o_imm = {{20{i_imm[11]}}, i_imm};
            decode_pkg::OPC_STORE:  o_imm = {{20{s_imm[11]}}, s_imm};
            decode_pkg::OPC_BRANCH: o_imm = {{19{b_imm[12]}}, b_imm};
            decode_pkg::OPC_JAL:    o_imm = {{11{j_imm[20]}}, j_imm};
            decode_pkg::OPC_LUI,
            decode_pkg::OPC_AUIPC:  o_imm = {i_instr[31:12], 12'b0};
            decode_pkg::OPC_SYSTEM: begin
                if (funct3[1:0] != 2'b00) begin
                    // CSR address low, zimm above it for the immediate forms
                    o_imm = {15'b0, (funct3[2] ? i_instr[19:15] : 5'b0), i_imm};
                end else begin
                    o_imm = 32'd4; // Return address offset for traps
                end
            end
            default: o_imm = '0;
        endcase
    end

endmodule

// File: design/decode_pkg.sv
`include "decode_cfg.svh"

package decode_pkg;

    // RV32I major opcodes kept by the stage
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_FENCE  = 7'b0001111,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [1:0] {EX_ALU, EX_LSU, EX_SFU} ex_unit_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    // Executed in the ALU with mod[0] set
    typedef enum logic [3:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR,
        BR_ECALL, BR_EBREAK, BR_URET, BR_SRET, BR_MRET
    } br_op_e;

    // Bit 3 is the store flag, bits 2:0 the funct3 size field
    typedef enum logic [3:0] {
        LSU_LB = 4'b0000, LSU_LH = 4'b0001, LSU_LW = 4'b0010,
        LSU_LBU = 4'b0100, LSU_LHU = 4'b0101,
        LSU_SB = 4'b1000, LSU_SH = 4'b1001, LSU_SW = 4'b1010,
        LSU_FENCE = 4'b1111
    } lsu_op_e;

    typedef enum logic [3:0] {SFU_CSRRW = 4'd1, SFU_CSRRS = 4'd2, SFU_CSRRC = 4'd3} sfu_op_e;

    typedef logic [2:0] op_mod_t; // bit 0 marks a branch op

    typedef struct packed {
        logic [`DEC_WID_W-1:0]   wid;
        logic [`DEC_INSTR_W-1:0] pc;
        ex_unit_e                unit;
        logic [3:0]              op;
        op_mod_t                 mod;
        logic                    use_pc;
        logic                    use_imm;
        logic [`DEC_INSTR_W-1:0] imm;
        logic                    wb;
        logic [`DEC_REG_W-1:0]   rd;
        logic [`DEC_REG_W-1:0]   rs1;
        logic [`DEC_REG_W-1:0]   rs2;
    } decoded_t;

endpackage

// File: design/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// Instruction and data path width
`define DEC_INSTR_W 32

// Register index width, RV32I has 32 registers
`define DEC_REG_W 5

// Warps per core and matching id width
`define DEC_NUM_WARPS 4
`define DEC_WID_W 2

// Entries in the output elastic buffer
`define DEC_BUF_DEPTH 2

`endif
